/* source/cvt_pkg.sv */
package cvt_pkg;

	// ====================
	// sizes
	// ====================
	localparam int LANES  = 8;  // bytes per word, lanes per output word
	localparam int MAX_AW = 12; // widest bank address carried in the structs

	// ====================
	// data types
	// ====================
	typedef logic [63:0] word_t; // byte 0 sits in bits 63:56
	typedef logic [7:0]  byte_t;

	typedef enum logic [2:0] {
		IDLE,
		STORE,
		SORT,
		OUTPUT,
		CLEAR
	} state_t;

	// one-hot phase enables, decoded from the state
	typedef struct packed {
		logic store;
		logic sort;
		logic out;
		logic clear; // synchronous counter clear
	} phase_t;

	// bank read request, lane_sort to stream_store
	typedef struct packed {
		logic              en;
		logic              bank; // 0 or 1
		logic [MAX_AW-1:0] addr; // upper bits unused for small banks
	} bank_rd_t;

	// sort ram write, lane_sort to frame_output
	typedef struct packed {
		logic            en;
		logic [7:0]      byte_en; // bit 7 is lane 0
		logic [MAX_AW:0] addr;
		word_t           data;
	} sort_wr_t;

	// reverse byte order of one word
	function automatic word_t swap_bytes(input word_t w);
		word_t s;
		for (int i = 0; i < LANES; i++) begin
			s[8*i +: 8] = w[8*(LANES-1-i) +: 8];
		end
		return s;
	endfunction

endpackage

/* source/cvt_fsm.sv */
`timescale 1ns/10ps

module cvt_fsm (
	input  logic             clk,
	input  logic             reset,
	input  logic             in_empty_n, // start condition
	input  logic             store_done,
	input  logic             sort_done,
	input  logic             out_done,
	output cvt_pkg::state_t  state,
	output cvt_pkg::phase_t  phase
);

	cvt_pkg::state_t state_q;
	cvt_pkg::state_t next_state;
	logic [2:0]      clr_sh; // clear length shift

	// ====================
	// state register
	// ====================
	always_ff @(posedge clk or posedge reset) begin
		if (reset) begin
			state_q <= cvt_pkg::IDLE;
		end else begin
			state_q <= next_state;
		end
	end

	// next state
	always_comb begin
		next_state = state_q; // hold by default
		case (state_q)
			cvt_pkg::IDLE:   if (in_empty_n) next_state = cvt_pkg::STORE;
			cvt_pkg::STORE:  if (store_done) next_state = cvt_pkg::SORT;
			cvt_pkg::SORT:   if (sort_done) next_state = cvt_pkg::OUTPUT;
			cvt_pkg::OUTPUT: if (out_done) next_state = cvt_pkg::CLEAR;
			cvt_pkg::CLEAR:  if (clr_sh[2]) next_state = cvt_pkg::IDLE;
			default:         next_state = cvt_pkg::IDLE;
		endcase
	end

	// ====================
	// clear timing
	// ====================
	// fills one stage per cycle while clear is (about to be) active,
	// top bit ends the third clear cycle
	always_ff @(posedge clk or posedge reset) begin
		if (reset) begin
			clr_sh <= 3'b000;
		end else if (next_state == cvt_pkg::CLEAR) begin
			clr_sh <= {clr_sh[1:0], 1'b1};
		end else begin
			clr_sh <= 3'b000;
		end
	end

	// phase decode
	always_comb begin
		phase.store = (state_q == cvt_pkg::STORE);
		phase.sort  = (state_q == cvt_pkg::SORT);
		phase.out   = (state_q == cvt_pkg::OUTPUT);
		phase.clear = (state_q == cvt_pkg::CLEAR);
	end

	assign state = state_q; // observation only

endmodule

/* source/bank_ram.sv */
`timescale 1ns/10ps

module bank_ram #(
	parameter int AW = 10
) (
	input  logic           clk,
	input  logic           en,
	input  logic [7:0]     byte_en, // bit b writes bits 8b+7:8b
	input  logic [AW-1:0]  addr,
	input  cvt_pkg::word_t wdata,
	output cvt_pkg::word_t rdata
);

	localparam int DEPTH = 2 ** AW;

	cvt_pkg::word_t mem [DEPTH];

	// read first, data one cycle after en
	always_ff @(posedge clk) begin
		if (en) begin
			rdata <= mem[addr];
			for (int b = 0; b < cvt_pkg::LANES; b++) begin
				if (byte_en[b]) begin
					mem[addr][8*b +: 8] <= wdata[8*b +: 8];
				end
			end
		end
	end

endmodule

/* source/stream_store.sv */
`timescale 1ns/10ps

module stream_store #(
	parameter int GROUPS     = 4,
	parameter int COL_BLOCKS = 32,
	parameter bit SWAP_BYTES = 1'b1
) (
	input  logic              clk,
	input  logic              reset,
	input  cvt_pkg::phase_t   phase,
	input  cvt_pkg::word_t    in_data,
	input  logic              in_empty_n,
	output logic              read,
	output logic              store_done,
	input  cvt_pkg::bank_rd_t rd,
	output cvt_pkg::word_t    bank_q
);

	localparam int BANK_WORDS = cvt_pkg::LANES * GROUPS * COL_BLOCKS;
	localparam int BANK_AW    = $clog2(BANK_WORDS);

	logic               accept;    // word taken this cycle
	logic [BANK_AW-1:0] wr_addr;
	logic               wr_bank;   // 0 fills first, then 1
	logic               addr_last;
	cvt_pkg::word_t     wdata;
	logic               rd_bank_q; // bank of the read in flight
	cvt_pkg::word_t     q [2];

	// ====================
	// input side
	// ====================
	assign read      = phase.store; // level strobe, whole store phase
	assign accept    = phase.store & in_empty_n;
	assign addr_last = (wr_addr == BANK_AW'(BANK_WORDS - 1));
	assign wdata     = SWAP_BYTES ? cvt_pkg::swap_bytes(in_data) : in_data;

	// last word of bank 1 closes the store
	assign store_done = accept & wr_bank & addr_last;

	always_ff @(posedge clk or posedge reset) begin
		if (reset) begin
			wr_addr <= '0;
			wr_bank <= 1'b0;
		end else if (phase.clear) begin
			wr_addr <= '0;
			wr_bank <= 1'b0;
		end else if (accept) begin
			wr_addr <= addr_last ? '0 : wr_addr + 1'b1;
			if (addr_last) begin
				wr_bank <= ~wr_bank; // next bank
			end
		end
	end

	// ====================
	// banks
	// ====================
	for (genvar b = 0; b < 2; b++) begin : g_bank
		logic               en;
		logic [7:0]         be;
		logic [BANK_AW-1:0] addr;

		// own writes in store, sort reads otherwise
		always_comb begin
			if (phase.store) begin
				en   = accept & (wr_bank == 1'(b));
				be   = 8'hff;
				addr = wr_addr;
			end else begin
				en   = rd.en & (rd.bank == 1'(b));
				be   = 8'h00;
				addr = rd.addr[BANK_AW-1:0];
			end
		end

		bank_ram #(.AW(BANK_AW)) u_bank (
			.clk     (clk),
			.en      (en),
			.byte_en (be),
			.addr    (addr),
			.wdata   (wdata),
			.rdata   (q[b])
		);
	end

	// bank bit follows the read by one cycle like the data
	always_ff @(posedge clk or posedge reset) begin
		if (reset) begin
			rd_bank_q <= 1'b0;
		end else if (rd.en) begin
			rd_bank_q <= rd.bank;
		end
	end

	assign bank_q = q[rd_bank_q];

endmodule

/* source/lane_sort.sv */
`timescale 1ns/10ps

module lane_sort #(
	parameter int GROUPS     = 4,
	parameter int COL_BLOCKS = 32
) (
	input  logic              clk,
	input  logic              reset,
	input  cvt_pkg::phase_t   phase,
	output cvt_pkg::bank_rd_t rd,
	input  cvt_pkg::word_t    bank_q,
	output cvt_pkg::sort_wr_t wr,
	output logic              sort_done
);

	localparam int LANES       = cvt_pkg::LANES;
	localparam int AW          = cvt_pkg::MAX_AW;
	localparam int FRAME_WORDS = 2 * LANES * GROUPS * COL_BLOCKS;
	localparam int GW          = (GROUPS > 1) ? $clog2(GROUPS) : 1;
	localparam int KW          = (COL_BLOCKS > 1) ? $clog2(COL_BLOCKS) : 1;

	// counter nest, inner to outer
	logic [2:0]    lane;
	logic [GW-1:0] grp;
	logic          bnk;
	logic [2:0]    col;  // byte column picked from the bank word
	logic [KW-1:0] blk;
	logic          reads_done;
	logic          lane_last;
	logic          grp_last;
	logic          col_last;
	logic          blk_last;
	logic [AW-1:0] rd_addr;

	// read data stage
	logic           v1;
	logic [2:0]     lane_d;
	logic [2:0]     col_d;
	cvt_pkg::byte_t col_byte;
	cvt_pkg::word_t placed;
	logic [7:0]     lane_be;

	// write stage
	logic [AW:0]    sort_addr;
	logic           wr_en_q;
	logic [7:0]     wr_be_q;
	logic [AW:0]    wr_addr_q;
	cvt_pkg::word_t wr_data_q;

	// ====================
	// read issue
	// ====================
	assign lane_last = (lane == 3'd7);
	assign grp_last  = (grp == GW'(GROUPS - 1));
	assign col_last  = (col == 3'd7);
	assign blk_last  = (blk == KW'(COL_BLOCKS - 1));

	// lane row of the group, block picks the column
	assign rd_addr = (AW'(grp) * AW'(LANES) + AW'(lane)) * AW'(COL_BLOCKS) + AW'(blk);

	always_comb begin
		rd.en   = phase.sort & ~reads_done; // one read per cycle
		rd.bank = bnk;
		rd.addr = rd_addr;
	end

	always_ff @(posedge clk or posedge reset) begin
		if (reset) begin
			lane       <= '0;
			grp        <= '0;
			bnk        <= 1'b0;
			col        <= '0;
			blk        <= '0;
			reads_done <= 1'b0;
		end else if (phase.clear) begin
			lane       <= '0;
			grp        <= '0;
			bnk        <= 1'b0;
			col        <= '0;
			blk        <= '0;
			reads_done <= 1'b0;
		end else if (rd.en) begin
			lane <= lane + 3'd1; // wraps at 8
			if (lane_last) begin
				grp <= grp_last ? '0 : grp + 1'b1;
			end
			if (lane_last & grp_last) begin
				bnk <= ~bnk;
			end
			if (lane_last & grp_last & bnk) begin
				col <= col + 3'd1;
			end
			if (lane_last & grp_last & bnk & col_last) begin
				blk <= blk_last ? '0 : blk + 1'b1;
			end
			if (lane_last & grp_last & bnk & col_last & blk_last) begin
				reads_done <= 1'b1; // whole frame issued
			end
		end
	end

	// ====================
	// byte gather
	// ====================
	// selectors trail the read by one cycle, same as bank_q
	always_ff @(posedge clk or posedge reset) begin
		if (reset) begin
			v1     <= 1'b0;
			lane_d <= '0;
			col_d  <= '0;
		end else begin
			v1     <= rd.en;
			lane_d <= lane;
			col_d  <= col;
		end
	end

	always_comb begin
		col_byte = bank_q[8*(LANES-1-int'(col_d)) +: 8];
		placed   = '0;
		placed[8*(LANES-1-int'(lane_d)) +: 8] = col_byte; // lane 0 at msb
		lane_be  = 8'h80 >> lane_d;
	end

	// sort address steps once all eight lanes are written
	always_ff @(posedge clk or posedge reset) begin
		if (reset) begin
			sort_addr <= '0;
			wr_en_q   <= 1'b0;
		end else if (phase.clear) begin
			sort_addr <= '0;
			wr_en_q   <= 1'b0;
		end else begin
			wr_en_q <= v1;
			if (v1 & (lane_d == 3'd7)) begin
				sort_addr <= sort_addr + 1'b1;
			end
		end
	end

	always_ff @(posedge clk) begin
		wr_be_q   <= lane_be;
		wr_addr_q <= sort_addr;
		wr_data_q <= placed;
	end

	always_comb begin
		wr.en      = wr_en_q;
		wr.byte_en = wr_be_q;
		wr.addr    = wr_addr_q;
		wr.data    = wr_data_q;
	end

	// lane 7 of the final word, last sort cycle
	assign sort_done = wr_en_q & wr_be_q[0] & (wr_addr_q == (AW+1)'(FRAME_WORDS - 1));

endmodule

/* source/frame_output.sv */
`timescale 1ns/10ps

module frame_output #(
	parameter int GROUPS     = 4,
	parameter int COL_BLOCKS = 32,
	parameter bit SWAP_BYTES = 1'b1
) (
	input  logic              clk,
	input  logic              reset,
	input  cvt_pkg::phase_t   phase,
	input  cvt_pkg::sort_wr_t wr,
	output cvt_pkg::word_t    out_data,
	output logic              write,
	output logic              last,
	output logic              out_done
);

	localparam int FRAME_WORDS = 2 * cvt_pkg::LANES * GROUPS * COL_BLOCKS;
	localparam int FRAME_AW    = $clog2(FRAME_WORDS);

	logic                out_act;  // output phase, one cycle late
	logic                rd_go;
	logic                rd_fin;   // all words read
	logic                addr_last;
	logic [FRAME_AW-1:0] out_addr;
	logic                ram_en;
	logic [7:0]          ram_be;
	logic [FRAME_AW-1:0] ram_addr;
	cvt_pkg::word_t      ram_q;
	logic                write_q;
	logic                last_q;

	// ====================
	// sort ram
	// ====================
	assign ram_en   = wr.en | rd_go;
	assign ram_be   = wr.en ? wr.byte_en : 8'h00;
	assign ram_addr = wr.en ? wr.addr[FRAME_AW-1:0] : out_addr;

	bank_ram #(.AW(FRAME_AW)) u_sort_ram (
		.clk     (clk),
		.en      (ram_en),
		.byte_en (ram_be),
		.addr    (ram_addr),
		.wdata   (wr.data),
		.rdata   (ram_q)
	);

	// ====================
	// linear readout
	// ====================
	assign rd_go     = phase.out & out_act & ~rd_fin;
	assign addr_last = (out_addr == FRAME_AW'(FRAME_WORDS - 1));

	always_ff @(posedge clk or posedge reset) begin
		if (reset) begin
			out_act  <= 1'b0;
			rd_fin   <= 1'b0;
			out_addr <= '0;
			write_q  <= 1'b0;
			last_q   <= 1'b0;
		end else if (phase.clear) begin
			out_act  <= 1'b0;
			rd_fin   <= 1'b0;
			out_addr <= '0;
			write_q  <= 1'b0;
			last_q   <= 1'b0;
		end else begin
			out_act <= phase.out;
			write_q <= rd_go;              // lines up with ram_q
			last_q  <= rd_go & addr_last;
			if (rd_go) begin
				out_addr <= addr_last ? '0 : out_addr + 1'b1;
				rd_fin   <= addr_last;
			end
		end
	end

	assign write    = write_q;
	assign last     = last_q;
	assign out_done = last_q; // leave output after the final word
	assign out_data = !write_q ? '0 : (SWAP_BYTES ? cvt_pkg::swap_bytes(ram_q) : ram_q);

endmodule

/* source/hw_cvtor.sv */
`timescale 1ns/10ps

module hw_cvtor #(
	parameter int GROUPS     = 4,
	parameter int COL_BLOCKS = 32,
	parameter bit SWAP_BYTES = 1'b1
) (
	input  logic            clk,
	input  logic            reset,
	// input stream
	input  cvt_pkg::word_t  in_data,
	input  logic            in_empty_n,
	output logic            read,
	// output stream, no back-pressure
	output cvt_pkg::word_t  out_data,
	output logic            write,
	output logic            last,
	output cvt_pkg::state_t state
);

	cvt_pkg::phase_t   phase;
	logic              store_done;
	logic              sort_done;
	logic              out_done;
	cvt_pkg::bank_rd_t rd;      // sort reads into the store banks
	cvt_pkg::word_t    bank_q;
	cvt_pkg::sort_wr_t wr;      // gathered bytes to the sort ram

	// ====================
	// control
	// ====================
	cvt_fsm u_fsm (
		.clk        (clk),
		.reset      (reset),
		.in_empty_n (in_empty_n),
		.store_done (store_done),
		.sort_done  (sort_done),
		.out_done   (out_done),
		.state      (state),
		.phase      (phase)
	);

	// ====================
	// datapath
	// ====================
	stream_store #(
		.GROUPS     (GROUPS),
		.COL_BLOCKS (COL_BLOCKS),
		.SWAP_BYTES (SWAP_BYTES)
	) u_store (
		.clk        (clk),
		.reset      (reset),
		.phase      (phase),
		.in_data    (in_data),
		.in_empty_n (in_empty_n),
		.read       (read),
		.store_done (store_done),
		.rd         (rd),
		.bank_q     (bank_q)
	);

	lane_sort #(
		.GROUPS     (GROUPS),
		.COL_BLOCKS (COL_BLOCKS)
	) u_sort (
		.clk       (clk),
		.reset     (reset),
		.phase     (phase),
		.rd        (rd),
		.bank_q    (bank_q),
		.wr        (wr),
		.sort_done (sort_done)
	);

	frame_output #(
		.GROUPS     (GROUPS),
		.COL_BLOCKS (COL_BLOCKS),
		.SWAP_BYTES (SWAP_BYTES)
	) u_output (
		.clk      (clk),
		.reset    (reset),
		.phase    (phase),
		.wr       (wr),
		.out_data (out_data),
		.write    (write),
		.last     (last),
		.out_done (out_done)
	);

endmodule

/* sim/tb_hw_cvtor.sv */
`timescale 1ns/10ps

module tb_hw_cvtor;

	localparam int GROUPS      = 2;
	localparam int COL_BLOCKS  = 2;
	localparam bit SWAP_BYTES  = 1'b1;
	localparam int BANK_WORDS  = 8 * GROUPS * COL_BLOCKS;
	localparam int FRAME_WORDS = 2 * BANK_WORDS;

	logic            clk;
	logic            reset;
	cvt_pkg::word_t  in_data;
	logic            in_empty_n;
	logic            read;
	cvt_pkg::word_t  out_data;
	logic            write;
	logic            last;
	cvt_pkg::state_t state;

	cvt_pkg::word_t  accepted[$];  // every word the DUT took in order
	logic            src_on;       // source offers words only when set
	int              writes_total; // writes seen over all frames
	int              err_idle;
	int              err_ctrl;
	int              err_data;
	int              err_timing;
	int              tests_run;
	int              failed_tests;

	hw_cvtor #(
		.GROUPS     (GROUPS),
		.COL_BLOCKS (COL_BLOCKS),
		.SWAP_BYTES (SWAP_BYTES)
	) i_hw_cvtor (
		.clk        (clk),
		.reset      (reset),
		.in_data    (in_data),
		.in_empty_n (in_empty_n),
		.read       (read),
		.out_data   (out_data),
		.write      (write),
		.last       (last),
		.state      (state)
	);

	// ====================
	// clock and reset
	// ====================
	initial begin
		clk = 1'b0;
		forever #4 clk = ~clk; // 8 ns period
	end

	initial begin
		reset = 1'b1;
		repeat (2) @(posedge clk);
		reset <= 1'b0;
	end

	// ====================
	// reference model
	// ====================
	function automatic cvt_pkg::word_t reverse_bytes(input cvt_pkg::word_t w);
		cvt_pkg::word_t r;
		r = {<<8{w}};
		return r;
	endfunction

	// output word j of the frame whose first accepted word is at base
	function automatic cvt_pkg::word_t expected_word(input int base, input int j);
		int             g;
		int             b;
		int             c;
		int             k;
		int             addr;
		cvt_pkg::word_t src;
		cvt_pkg::word_t res;
		g   = j % GROUPS;
		b   = (j / GROUPS) % 2;
		c   = (j / (GROUPS * 2)) % 8;
		k   = j / (GROUPS * 16);
		res = '0;
		for (int l = 0; l < 8; l++) begin
			addr = l * COL_BLOCKS + g * 8 * COL_BLOCKS + k;
			src  = accepted[base + b * BANK_WORDS + addr];
			if (SWAP_BYTES) begin
				src = reverse_bytes(src); // input swap before the banks
			end
			res[8*(7-l) +: 8] = src[8*(7-c) +: 8]; // byte 0 is msb
		end
		return SWAP_BYTES ? reverse_bytes(res) : res;
	endfunction

	// ====================
	// stimulus and monitors
	// ====================
	initial begin
		logic took;
		void'($urandom(32'hcbb6));
		in_data    = {$urandom, $urandom};
		in_empty_n = 1'b0;
		forever begin
			@(negedge clk);
			took = read && in_empty_n; // taken at the coming edge
			if (took) begin
				accepted.push_back(in_data);
			end
			@(posedge clk);
			if (took) begin
				in_data <= {$urandom, $urandom}; // next head word
			end
			in_empty_n <= src_on && (($urandom % 4) != 0); // random gaps
		end
	end

	// read strobe tracks the store state
	initial begin
		forever begin
			@(negedge clk);
			if (!reset && ((read === 1'b1) != (state == cvt_pkg::STORE))) begin
				$display("ERR %0t: read %b in state %s", $time, read, state.name());
				err_ctrl++;
			end
		end
	end

	// compares every output word as it leaves
	initial begin
		int             idx;
		int             base;
		cvt_pkg::word_t exp_w;
		logic           prev_write;
		prev_write = 1'b0;
		forever begin
			@(negedge clk);
			idx  = writes_total % FRAME_WORDS;
			base = writes_total - idx;
			if (write === 1'b1) begin
				if (accepted.size() < base + FRAME_WORDS) begin
					$display("ERR %0t: write before frame fully stored", $time);
					err_timing++;
				end else begin
					exp_w = expected_word(base, idx);
					if (out_data !== exp_w) begin
						$display("ERR %0t: word %0d got %h expected %h", $time, idx,
							out_data, exp_w);
						err_data++;
					end
				end
				if (last !== (idx == FRAME_WORDS - 1)) begin
					$display("ERR %0t: last %b on word %0d", $time, last, idx);
					err_timing++;
				end
				if (idx > 0 && !prev_write) begin
					$display("ERR %0t: gap before word %0d", $time, idx);
					err_timing++;
				end
				if (state != cvt_pkg::OUTPUT) begin
					$display("ERR %0t: write in state %s", $time, state.name());
					err_timing++;
				end
				writes_total++;
			end else if (!reset && (last !== 1'b0 || out_data !== '0)) begin
				$display("ERR %0t: last %b data %h without write", $time, last, out_data);
				err_timing++;
			end
			prev_write = (write === 1'b1);
		end
	end

	// ====================
	// sequence helpers
	// ====================
	task automatic abort_run(input string why);
		$display("timeout at %0t while waiting for %s", $time, why);
		$display("Test failed");
		$finish;
	endtask

	task automatic wait_state(input cvt_pkg::state_t s, input int limit, input string what);
		int n;
		n = 0;
		while (state !== s) begin
			@(negedge clk);
			n++;
			if (n > limit) begin
				abort_run(what);
			end
		end
	endtask

	task automatic wait_writes(input int target, input int limit, input string what);
		int n;
		n = 0;
		while (writes_total < target) begin
			@(negedge clk);
			n++;
			if (n > limit) begin
				abort_run(what);
			end
		end
	endtask

	task automatic report_test(input int num, input string name, input int errs);
		tests_run++;
		if (errs == 0) begin
			$display("test %0d %s: ok", num, name);
		end else begin
			$display("test %0d %s: %0d errors", num, name, errs);
			failed_tests++;
		end
	endtask

	// one whole frame from store through clear
	task automatic run_frame(input int f);
		src_on = 1'b1;
		wait_state(cvt_pkg::STORE, 100, "store to start");
		wait_state(cvt_pkg::SORT, 1000, "store to end");
		src_on = 1'b0;
		if (accepted.size() != (f + 1) * FRAME_WORDS) begin
			$display("ERR %0t: %0d words accepted, expected %0d", $time,
				accepted.size(), (f + 1) * FRAME_WORDS);
			err_ctrl++;
		end
		wait_writes((f + 1) * FRAME_WORDS, 1000, "output words");
		wait_state(cvt_pkg::IDLE, 20, "return to idle");
		if (writes_total != (f + 1) * FRAME_WORDS) begin
			$display("ERR %0t: %0d writes, expected %0d", $time, writes_total,
				(f + 1) * FRAME_WORDS);
			err_timing++;
		end
	endtask

	// ====================
	// main sequence
	// ====================
	initial begin
		int ctrl0;
		int data0;
		int tim0;
		int total0;
		int total;
		src_on       = 1'b0;
		writes_total = 0;
		err_idle     = 0;
		err_ctrl     = 0;
		err_data     = 0;
		err_timing   = 0;
		tests_run    = 0;
		failed_tests = 0;
		repeat (3) @(negedge clk);

		// nothing may move while the input is quiet
		for (int i = 0; i < 12; i++) begin
			@(negedge clk);
			if (read !== 1'b0 || write !== 1'b0 || last !== 1'b0 ||
				state !== cvt_pkg::IDLE) begin
				$display("ERR %0t: not idle, read %b write %b last %b state %s", $time,
					read, write, last, state.name());
				err_idle++;
			end
		end
		report_test(1, "idle after reset", err_idle);

		ctrl0 = err_ctrl;
		data0 = err_data;
		tim0  = err_timing;
		run_frame(0);
		report_test(2, "store strobe and word count", err_ctrl - ctrl0);
		report_test(3, "first frame output data", err_data - data0);
		report_test(4, "first frame write timing", err_timing - tim0);

		total0 = err_ctrl + err_data + err_timing;
		run_frame(1); // counters must have cleared
		total = err_ctrl + err_data + err_timing;
		report_test(5, "second frame after clear", total - total0);

		total = total + err_idle;
		$display("tests %0d, failed %0d, errors %0d", tests_run, failed_tests, total);
		if (total == 0 && failed_tests == 0) begin
			$display("Test passed");
		end else begin
			$display("Test failed");
		end
		$finish;
	end

endmodule

/* list.f */
source/cvt_pkg.sv
source/cvt_fsm.sv
source/bank_ram.sv
source/stream_store.sv
source/lane_sort.sv
source/frame_output.sv
source/hw_cvtor.sv
sim/tb_hw_cvtor.sv

/* run.sh */
#!/bin/bash
cd "$(dirname "$0")" || exit 1
rm -rf obj_dir sim.log
verilator --binary --timing -Wno-fatal -f list.f --top-module tb_hw_cvtor \
	-o tb_hw_cvtor > sim.log 2>&1 \
	&& ./obj_dir/tb_hw_cvtor >> sim.log 2>&1 \
	|| { cat sim.log; echo "build or run error"; exit 1; }
cat sim.log
grep -q "Test failed" sim.log && { echo "simulation reported FAIL"; exit 1; }
grep -q "Test passed" sim.log || { echo "no result found in sim.log"; exit 1; }
exit 0
